/* spi_vga_display.f */
+incdir+verilog
verilog/spi_cmd_pkg.sv
verilog/vga_pkg.sv
verilog/spi_byte_receiver.sv
verilog/command_decoder.sv
verilog/frame_buffer.sv
verilog/scan_timing.sv
verilog/pixel_output.sv
verilog/spi_vga_display.sv
dv/tb_spi_vga_display.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_spi_vga_display
FILELIST  = spi_vga_display.f
OBJ_DIR   = obj_dir
PASS_MSG  = No errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* dv/tb_spi_vga_display.sv */
`timescale 1ns/100ps
`include "fb_params.svh"

module tb_spi_vga_display;

    localparam int     clk_period = 40;
    localparam int     frame_clks = `H_TOTAL * `V_TOTAL * `PIX_DIV;
    localparam int     byte_clks  = 72;
    localparam int     first_run  = 700;
    localparam int     second_run = 700;
    localparam int     third_run  = 300;
    localparam int     num_bytes  = first_run + second_run + third_run + 5;
    localparam int     num_frames = 7;
    localparam longint timeout_ns = longint'(clk_period)
                                  * (longint'(num_frames) * frame_clks + num_bytes * byte_clks);

    logic              clk = 1'b0;
    logic              rst;
    logic              sclk;
    logic              cs_n;
    logic              mosi;
    logic [`VGA_W-1:0] vga_r;
    logic [`VGA_W-1:0] vga_g;
    logic [`VGA_W-1:0] vga_b;
    logic              h_sync;
    logic              v_sync;

    // Reference model, two buffers plus marks for written words
    logic [`COLOR_W-1:0] ref_mem [2][`FB_DEPTH];
    bit                  ref_valid [2][`FB_DEPTH];
    int                  ref_addr;
    bit                  ref_front;
    bit                  ref_pending;

    // Raster tracker
    int   h_clks;
    int   v;
    bit   h_locked;
    bit   v_locked;
    logic h_sync_q;
    logic v_sync_q;
    int   frames_seen;

    spi_vga_display dut0 (
        .clk(clk), .rst(rst), .sclk(sclk), .cs_n(cs_n), .mosi(mosi),
        .vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b), .h_sync(h_sync), .v_sync(v_sync)
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic check_value(input int actual, input int expected, input string what);
        if (actual != expected) begin
            $display("FAILED at %0t: %s is %0h, expected %0h", $time, what, actual, expected);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    function automatic bit in_active_area(input int h, input int vl);
        return (h >= `H_ACT_START) && (h < `H_ACT_START + `H_ACT)
            && (vl >= `V_ACT_START) && (vl < `V_ACT_START + `V_ACT);
    endfunction

    // Each framebuffer word covers a SCALE x SCALE block on screen
    function automatic int screen_addr(input int h, input int vl);
        return ((vl - `V_ACT_START) / `SCALE) * `FB_WIDTH + (h - `H_ACT_START) / `SCALE;
    endfunction

    function automatic vga_pkg::rgb_t expected_rgb(input int h, input int vl);
        vga_pkg::rgb_t       rgb;
        logic [`COLOR_W-1:0] c;
        rgb = '0;
        if (in_active_area(h, vl)) begin
            c     = ref_mem[ref_front][screen_addr(h, vl)];
            rgb.r = {c[5:4], 2'b00};
            rgb.g = {c[3:2], 2'b00};
            rgb.b = {c[1:0], 2'b00};
        end
        return rgb;
    endfunction

    // ========================================================================
    // SPI host, mode 0, MSB first, sclk period of 8 clk
    // ========================================================================
    task automatic send_byte(input logic [`BYTE_W-1:0] data);
        @(negedge clk);
        cs_n = 1'b0;
        for (int i = `BYTE_W - 1; i >= 0; i--) begin
            mosi = data[i];
            repeat (4) @(negedge clk);
            sclk = 1'b1;
            repeat (4) @(negedge clk);
            sclk = 1'b0;
        end
        repeat (2) @(negedge clk);
        cs_n = 1'b1;
        repeat (4) @(negedge clk);
    endtask

    task automatic write_pixel(input logic [`COLOR_W-1:0] color);
        send_byte({2'b00, color});
        ref_mem[!ref_front][ref_addr]   = color;
        ref_valid[!ref_front][ref_addr] = 1'b1;
        ref_addr = (ref_addr + 1) % `FB_DEPTH;
    endtask

    task automatic write_random_pixels(input int count);
        for (int i = 0; i < count; i++) begin
            write_pixel(`COLOR_W'($urandom));
        end
    endtask

    task automatic realign(input logic [`BYTE_W-1:0] code);
        send_byte(code);
        ref_addr = 0;
    endtask

    // Kept well away from a frame start so the model and DUT agree on the frame
    task automatic request_swap();
        while (!v_locked || v < 5 || v > `V_TOTAL - 5) begin
            @(negedge clk);
        end
        send_byte(8'h81);
        repeat (8) @(negedge clk);
        ref_pending = 1'b1;
    endtask

    task automatic wait_frames(input int count);
        int target;
        target = frames_seen + count;
        while (frames_seen < target) begin
            @(negedge clk);
        end
    endtask

    // ========================================================================
    // Raster tracker and comparison, sampled mid-cycle
    // ========================================================================
    always @(negedge clk) begin
        int            h;
        bit            h_fall;
        bit            v_fall;
        vga_pkg::rgb_t exp_rgb;
        if (!rst) begin
            h_fall = h_sync_q && !h_sync;
            v_fall = v_sync_q && !v_sync;
            if (h_fall) begin
                if (h_locked) begin
                    check_value(h_clks + 1, `H_TOTAL * `PIX_DIV, "h_sync period in clk");
                end
                h_clks   = 0;
                h_locked = 1'b1;
            end else begin
                h_clks++;
            end
            if (v_fall) begin
                if (v_locked) begin
                    check_value(v + 1, `V_TOTAL, "v_sync period in lines");
                end
                v        = 0;
                v_locked = 1'b1;
                frames_seen++;
                // Pending swap shows from this frame on
                if (ref_pending) begin
                    ref_front   = !ref_front;
                    ref_pending = 1'b0;
                end
            end else if (h_fall) begin
                v++;
            end
            h = h_clks / `PIX_DIV;
            if (h_locked) begin
                check_value(int'(h_sync), int'(h >= `H_SYNC), "h_sync level");
            end
            if (h_locked && v_locked) begin
                check_value(int'(v_sync), int'(v >= `V_SYNC), "v_sync level");
                // Unwritten words hold no known color
                if (!in_active_area(h, v) || ref_valid[ref_front][screen_addr(h, v)]) begin
                    exp_rgb = expected_rgb(h, v);
                    check_value(int'({vga_r, vga_g, vga_b}), int'(exp_rgb), "rgb");
                end
            end
            h_sync_q = h_sync;
            v_sync_q = v_sync;
        end
    end

    // ========================================================================
    // Stimulus
    // ========================================================================
    initial begin
        void'($urandom(6861));
        rst         = 1'b1;
        sclk        = 1'b0;
        cs_n        = 1'b1;
        mosi        = 1'b0;
        ref_addr    = 0;
        ref_front   = 1'b0;
        ref_pending = 1'b0;
        h_locked    = 1'b0;
        v_locked    = 1'b0;
        h_sync_q    = 1'b1;
        v_sync_q    = 1'b1;
        h_clks      = 0;
        v           = 0;
        frames_seen = 0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        wait_frames(1);

        // Fill the back buffer, then show it for a whole frame
        realign(8'h80);
        write_random_pixels(first_run);
        request_swap();
        wait_frames(2);

        // New writes stay hidden while the front buffer is on screen
        realign(8'h80);
        write_random_pixels(second_run);
        wait_frames(1);

        // Unknown control code restarts at address 0
        realign(8'hC5);
        write_random_pixels(third_run);
        request_swap();
        wait_frames(2);

        $display("No errors");
        $finish;
    end

    initial begin
        #(timeout_ns);
        $display("Timeout at %0t, the display tests did not finish", $time);
        $display("Errors found");
        $fatal(1);
    end

endmodule

/* verilog/spi_vga_display.sv */
`timescale 1ns/100ps
`include "fb_params.svh"

module spi_vga_display (
    input  logic              clk,
    input  logic              rst,
    input  logic              sclk,
    input  logic              cs_n,
    input  logic              mosi,
    output logic [`VGA_W-1:0] vga_r,
    output logic [`VGA_W-1:0] vga_g,
    output logic [`VGA_W-1:0] vga_b,
    output logic              h_sync,
    output logic              v_sync
);

    logic                   byte_valid;
    logic [`BYTE_W-1:0]     byte_data;
    spi_cmd_pkg::fb_write_t wr;
    logic                   swap_req;
    vga_pkg::scan_pos_t     pos;
    logic [`COLOR_W-1:0]    rd_color;
    vga_pkg::rgb_t          rgb;

    spi_byte_receiver u_rx (
        .clk(clk), .rst(rst), .sclk(sclk), .cs_n(cs_n), .mosi(mosi),
        .byte_valid(byte_valid), .byte_data(byte_data)
    );

    command_decoder u_dec (
        .clk(clk), .rst(rst), .byte_valid(byte_valid), .byte_data(byte_data),
        .wr(wr), .swap_req(swap_req)
    );

    frame_buffer u_fb (
        .clk(clk), .rst(rst), .wr(wr), .swap_req(swap_req), .pos(pos),
        .rd_color(rd_color)
    );

    scan_timing u_scan (.clk(clk), .rst(rst), .pos(pos));

    pixel_output u_out (
        .clk(clk), .rst(rst), .pos(pos), .rd_color(rd_color),
        .rgb(rgb), .h_sync(h_sync), .v_sync(v_sync)
    );

    // Color channels to the pins
    assign vga_r = rgb.r;
    assign vga_g = rgb.g;
    assign vga_b = rgb.b;

endmodule

/* verilog/pixel_output.sv */
`timescale 1ns/100ps
`include "fb_params.svh"

module pixel_output (
    input  logic                clk,
    input  logic                rst,
    input  vga_pkg::scan_pos_t  pos,
    input  logic [`COLOR_W-1:0] rd_color,
    output vga_pkg::rgb_t       rgb,
    output logic                h_sync,
    output logic                v_sync
);

    // Flags aligned with rd_color
    logic active_d;
    logic h_sync_d;
    logic v_sync_d;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active_d <= 1'b0;
            h_sync_d <= 1'b1;
            v_sync_d <= 1'b1;
            rgb      <= '0;
            h_sync   <= 1'b1;
            v_sync   <= 1'b1;
        end else begin
            active_d <= pos.active;
            h_sync_d <= pos.h_sync;
            v_sync_d <= pos.v_sync;
            h_sync   <= h_sync_d;
            v_sync   <= v_sync_d;
            // 2-bit fields into the top of each 4-bit channel
            rgb.r    <= active_d ? {rd_color[5:4], 2'b00} : '0;
            rgb.g    <= active_d ? {rd_color[3:2], 2'b00} : '0;
            rgb.b    <= active_d ? {rd_color[1:0], 2'b00} : '0;
        end
    end

endmodule

/* verilog/scan_timing.sv */
`timescale 1ns/100ps
`include "fb_params.svh"

module scan_timing (
    input  logic               clk,
    input  logic               rst,
    output vga_pkg::scan_pos_t pos
);

    localparam int div_w = $clog2(`PIX_DIV);
    localparam int h_w   = $clog2(`H_TOTAL);
    localparam int v_w   = $clog2(`V_TOTAL);

    logic [div_w-1:0]     div_cnt;
    logic                 tick;
    logic [h_w-1:0]       h_cnt;
    logic [v_w-1:0]       v_cnt;
    logic [h_w-1:0]       h_scaled;
    logic [v_w-1:0]       v_scaled;
    vga_pkg::scan_phase_e h_phase;
    vga_pkg::scan_phase_e v_phase;

    function automatic vga_pkg::scan_phase_e phase_of(input int cnt, input int sync_len,
                                                      input int act_start, input int act_len);
        if (cnt < sync_len) begin
            return vga_pkg::phase_sync;
        end else if (cnt < act_start) begin
            return vga_pkg::phase_back_porch;
        end else if (cnt < act_start + act_len) begin
            return vga_pkg::phase_active;
        end
        return vga_pkg::phase_front_porch;
    endfunction

    // ======================================================================
    // Pixel tick and raster counters
    // ======================================================================
    assign tick = (div_cnt == div_w'(`PIX_DIV - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_cnt <= '0;
            h_cnt   <= '0;
            v_cnt   <= '0;
        end else begin
            div_cnt <= tick ? '0 : div_cnt + 1'b1;
            if (tick) begin
                if (h_cnt == h_w'(`H_TOTAL - 1)) begin
                    h_cnt <= '0;
                    v_cnt <= (v_cnt == v_w'(`V_TOTAL - 1)) ? '0 : v_cnt + 1'b1;
                end else begin
                    h_cnt <= h_cnt + 1'b1;
                end
            end
        end
    end

    // Phases and position
    assign h_phase  = phase_of(int'(h_cnt), `H_SYNC, `H_ACT_START, `H_ACT);
    assign v_phase  = phase_of(int'(v_cnt), `V_SYNC, `V_ACT_START, `V_ACT);
    assign h_scaled = (h_cnt - h_w'(`H_ACT_START)) / h_w'(`SCALE);
    assign v_scaled = (v_cnt - v_w'(`V_ACT_START)) / v_w'(`SCALE);

    always_comb begin
        pos.h_sync      = (h_phase != vga_pkg::phase_sync);
        pos.v_sync      = (v_phase != vga_pkg::phase_sync);
        pos.active      = (h_phase == vga_pkg::phase_active)
                       && (v_phase == vga_pkg::phase_active);
        // Parked at the origin while blanked
        pos.fb_x        = pos.active ? h_scaled[$bits(pos.fb_x)-1:0] : '0;
        pos.fb_y        = pos.active ? v_scaled[$bits(pos.fb_y)-1:0] : '0;
        pos.frame_start = (h_cnt == '0) && (v_cnt == '0);
        pos.tick        = tick;
    end

endmodule

/* verilog/frame_buffer.sv */
`timescale 1ns/100ps
`include "fb_params.svh"

module frame_buffer (
    input  logic                   clk,
    input  logic                   rst,
    input  spi_cmd_pkg::fb_write_t wr,
    input  logic                   swap_req,
    input  vga_pkg::scan_pos_t     pos,
    output logic [`COLOR_W-1:0]    rd_color
);

    logic [`COLOR_W-1:0]   mem [2][`FB_DEPTH];
    logic [`COLOR_W-1:0]   rd_q [2];
    logic [`FB_ADDR_W-1:0] rd_addr;
    logic                  front_sel;
    logic                  sel_q;
    logic                  swap_pending;

    // ======================================================================
    // Buffer swap, only at the first tick of a frame
    // ======================================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            front_sel    <= 1'b0;
            swap_pending <= 1'b0;
            sel_q        <= 1'b0;
        end else begin
            sel_q <= front_sel;
            if (pos.frame_start && pos.tick && swap_pending) begin
                front_sel    <= ~front_sel;
                // A request on this very cycle waits for the next frame
                swap_pending <= swap_req;
            end else if (swap_req) begin
                swap_pending <= 1'b1;
            end
        end
    end

    // ======================================================================
    // Memories: writes to the back half, reads from both
    // ======================================================================
    assign rd_addr = `FB_ADDR_W'(pos.fb_y) * `FB_ADDR_W'(`FB_WIDTH)
                   + `FB_ADDR_W'(pos.fb_x);

    always_ff @(posedge clk) begin
        for (int b = 0; b < 2; b++) begin
            if (wr.wen && (1'(b) != front_sel)) begin
                mem[b][wr.addr] <= wr.color;
            end
            rd_q[b] <= mem[b][rd_addr];
        end
    end

    // Select follows the read by one clk
    assign rd_color = rd_q[sel_q];

endmodule

/* verilog/command_decoder.sv */
`timescale 1ns/100ps
`include "fb_params.svh"

module command_decoder (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  byte_valid,
    input  logic [`BYTE_W-1:0]    byte_data,
    output spi_cmd_pkg::fb_write_t wr,
    output logic                  swap_req
);

    localparam logic [`FB_ADDR_W-1:0] last_addr = `FB_ADDR_W'(`FB_DEPTH - 1);
    localparam logic [`BYTE_W-1:0]    swap_code = `BYTE_W'(8'h81);

    spi_cmd_pkg::cmd_kind_e kind;
    logic [`FB_ADDR_W-1:0]  addr_cnt;

    // Bit 7 low is a pixel, any unknown control code aligns
    always_comb begin
        if (!byte_data[`BYTE_W-1]) begin
            kind = spi_cmd_pkg::cmd_pixel;
        end else if (byte_data == swap_code) begin
            kind = spi_cmd_pkg::cmd_swap;
        end else begin
            kind = spi_cmd_pkg::cmd_align;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr       <= '0;
            swap_req <= 1'b0;
            addr_cnt <= '0;
        end else begin
            wr.wen   <= 1'b0;
            swap_req <= 1'b0;
            if (byte_valid) begin
                case (kind)
                    spi_cmd_pkg::cmd_pixel: begin
                        wr.wen   <= 1'b1;
                        wr.addr  <= addr_cnt;
                        wr.color <= byte_data[`COLOR_W-1:0];
                        // Wrap at end of frame
                        addr_cnt <= (addr_cnt == last_addr) ? '0 : addr_cnt + 1'b1;
                    end
                    spi_cmd_pkg::cmd_swap: begin
                        swap_req <= 1'b1;
                    end
                    default: begin
                        addr_cnt <= '0;
                    end
                endcase
            end
        end
    end

endmodule

/* verilog/spi_byte_receiver.sv */
`timescale 1ns/100ps
`include "fb_params.svh"

module spi_byte_receiver (
    input  logic               clk,
    input  logic               rst,
    input  logic               sclk,
    input  logic               cs_n,
    input  logic               mosi,
    output logic               byte_valid,
    output logic [`BYTE_W-1:0] byte_data
);

    localparam int cnt_w = $clog2(`BYTE_W);

    logic [`BYTE_W-1:0]      shift_reg;
    logic [`BYTE_W-1:0]      next_byte;
    logic [`BYTE_W-1:0]      capture;
    logic [cnt_w-1:0]        bit_cnt;
    logic                    last_bit;
    logic                    toggle;
    logic [2:0]              toggle_sync;
    logic [1:0][`BYTE_W-1:0] data_sync;
    logic                    new_byte;

    // ======================================================================
    // sclk domain, mode 0, MSB first
    // ======================================================================
    assign next_byte = {shift_reg[`BYTE_W-2:0], mosi};
    assign last_bit  = (bit_cnt == cnt_w'(`BYTE_W - 1));

    always_ff @(posedge sclk) begin
        if (!cs_n) begin
            shift_reg <= next_byte;
        end
    end

    // Deselect drops any partial byte
    always_ff @(posedge sclk or posedge rst or posedge cs_n) begin
        if (rst || cs_n) begin
            bit_cnt <= '0;
        end else if (last_bit) begin
            bit_cnt <= '0;
        end else begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    // Full byte held stable until the next one completes
    always_ff @(posedge sclk) begin
        if (!cs_n && last_bit) begin
            capture <= next_byte;
        end
    end

    always_ff @(posedge sclk or posedge rst) begin
        if (rst) begin
            toggle <= 1'b0;
        end else if (!cs_n && last_bit) begin
            toggle <= ~toggle;
        end
    end

    // ======================================================================
    // Crossing into clk
    // ======================================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            toggle_sync <= '0;
        end else begin
            toggle_sync <= {toggle_sync[1:0], toggle};
        end
    end

    // Data stage runs in step with the first two toggle flops
    always_ff @(posedge clk) begin
        data_sync <= {data_sync[0], capture};
    end

    assign new_byte = toggle_sync[2] ^ toggle_sync[1];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= new_byte;
        end
    end

    always_ff @(posedge clk) begin
        if (new_byte) begin
            byte_data <= data_sync[1];
        end
    end

endmodule

/* verilog/vga_pkg.sv */
package vga_pkg;

    // Raster phase, shared by the horizontal and vertical counters
    typedef enum logic [1:0] {
        phase_sync        = 2'd0,
        phase_back_porch  = 2'd1,
        phase_active      = 2'd2,
        phase_front_porch = 2'd3
    } scan_phase_e;

    // Current scan position and flags, valid for one tick
    typedef struct packed {
        logic [8:0] fb_x;
        logic [7:0] fb_y;
        logic       h_sync;
        logic       v_sync;
        logic       active;
        logic       frame_start;
        logic       tick;
    } scan_pos_t;

    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

endpackage

/* verilog/spi_cmd_pkg.sv */
package spi_cmd_pkg;

    // Kind of an incoming SPI byte
    typedef enum logic [1:0] {
        cmd_pixel = 2'd0,
        cmd_align = 2'd1,
        cmd_swap  = 2'd2
    } cmd_kind_e;

    // One framebuffer write, color in RRGGBB form
    typedef struct packed {
        logic        wen;
        logic [16:0] addr;
        logic [5:0]  color;
    } fb_write_t;

endpackage

/* verilog/fb_params.svh */
`ifndef FB_PARAMS_SVH
`define FB_PARAMS_SVH

// ==========================================================================
// Framebuffer geometry
// ==========================================================================
`define FB_WIDTH     320
`define FB_HEIGHT    240
`define FB_DEPTH     76800
`define FB_ADDR_W    17
`define SCALE        2

// Clocks per pixel tick
`define PIX_DIV      2

// ==========================================================================
// 640x480 raster in an 800x525 frame, counted in ticks and lines
// ==========================================================================
`define H_TOTAL      800
`define H_SYNC       96
`define H_ACT_START  144
`define H_ACT        640
`define V_TOTAL      525
`define V_SYNC       2
`define V_ACT_START  35
`define V_ACT        480

// Data widths
`define BYTE_W       8
`define COLOR_W      6
`define VGA_W        4

`endif
